/* rtl/retire_macros.svh */
`ifndef RETIRE_MACROS_SVH
`define RETIRE_MACROS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
// Data word and pc
`define RETIRE_XLEN 32

// Integer register index
`define RETIRE_REG_W 5

// CSR address
`define RETIRE_CSR_W 12

// --------------------------------------------------
// Reset values
// --------------------------------------------------
`define RETIRE_MTVEC_RESET 32'h0000_0100

`endif

/* rtl/retire_pkg.sv */
`default_nettype none

package retire_pkg;

  // --------------------------------------------------
  // Instruction class as seen at retire
  // --------------------------------------------------
  typedef enum logic [2:0] {
    OP_ALU   = 3'd0,  // data word goes to rd
    OP_CSRR  = 3'd1,
    OP_CSRRW = 3'd2,
    OP_ECALL = 3'd3,
    OP_MRET  = 3'd4
  } op_e;

  // --------------------------------------------------
  // Four-phase handshake FSM
  // --------------------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE         = 2'd0,
    ST_ACK          = 2'd1,
    // Ack held until the source drops req
    ST_WAIT_REQ_LOW = 2'd2
  } state_e;

endpackage

`default_nettype wire

/* rtl/csr_pkg.sv */
`default_nettype none

`include "retire_macros.svh"

package csr_pkg;

  // --------------------------------------------------
  // Implemented machine CSRs
  // --------------------------------------------------
  typedef enum logic [`RETIRE_CSR_W-1:0] {
    CSR_MTVEC        = 12'h305,
    CSR_MEPC         = 12'h341,
    CSR_MCAUSE       = 12'h342,
    // Counters below are read-only here
    CSR_MINSTRET     = 12'hB02,
    CSR_MHPMCOUNTER3 = 12'hB03
  } csr_addr_e;

  // --------------------------------------------------
  // Exception causes written to mcause
  // --------------------------------------------------
  typedef enum logic [`RETIRE_XLEN-1:0] {
    CAUSE_ILLEGAL_INSTR = 32'd2,
    CAUSE_ECALL_M       = 32'd11
  } cause_e;

endpackage

`default_nettype wire

/* rtl/perf_counters.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_macros.svh"

module perf_counters (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // One-cycle events from retire control
  input  logic                    retired_i,
  input  logic                    trapped_i,
  // Values for CSR reads
  output logic [`RETIRE_XLEN-1:0] minstret_o,
  output logic [`RETIRE_XLEN-1:0] trap_count_o
);

  localparam int unsigned NUM_CNT = 2;

  // Index 0 is minstret, index 1 the trap count
  logic [NUM_CNT-1:0]                    inc;
  logic [NUM_CNT-1:0][`RETIRE_XLEN-1:0] count_q;

  assign inc = {trapped_i, retired_i};

  // --------------------------------------------------
  // Wrapping event counters
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        if (inc[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  end

  assign minstret_o   = count_q[0];
  assign trap_count_o = count_q[1];

  // One event per handshake, never both kinds at once
  single_event_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (retired_i || trapped_i) |->
      !(retired_i && trapped_i) ##1 !(retired_i || trapped_i))
    else $error("retire and trap events overlap or repeat");

endmodule

`default_nettype wire

/* rtl/csr_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_macros.svh"

module csr_regfile (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Access from retire control
  input  logic [`RETIRE_CSR_W-1:0] csr_addr_i,
  input  logic [`RETIRE_XLEN-1:0]  csr_wdata_i,
  input  logic                     csr_re_i,
  input  logic                     csr_we_i,
  output logic [`RETIRE_XLEN-1:0]  csr_rdata_o,
  output logic                     csr_illegal_o,
  // Trap entry
  input  logic                     trap_valid_i,
  input  logic [`RETIRE_XLEN-1:0]  trap_pc_i,
  input  csr_pkg::cause_e          trap_cause_i,
  // Counter values
  input  logic [`RETIRE_XLEN-1:0]  minstret_i,
  input  logic [`RETIRE_XLEN-1:0]  trap_count_i,
  // Redirect targets
  output logic [`RETIRE_XLEN-1:0]  mtvec_o,
  output logic [`RETIRE_XLEN-1:0]  mepc_o
);

  logic [`RETIRE_XLEN-1:0] mtvec_q;
  logic [`RETIRE_XLEN-1:0] mepc_q;
  logic [`RETIRE_XLEN-1:0] mcause_q;

  logic addr_known;
  logic addr_ro;
  logic write_ok;
  logic mtvec_we;
  logic mepc_we;
  logic mcause_we;

  // --------------------------------------------------
  // Address decode and read mux
  // --------------------------------------------------
  always_comb begin
    addr_known  = 1'b1;
    addr_ro     = 1'b0;
    csr_rdata_o = '0;
    case (csr_addr_i)
      csr_pkg::CSR_MTVEC: begin
        csr_rdata_o = mtvec_q;
      end
      csr_pkg::CSR_MEPC: begin
        csr_rdata_o = mepc_q;
      end
      csr_pkg::CSR_MCAUSE: begin
        csr_rdata_o = mcause_q;
      end
      csr_pkg::CSR_MINSTRET: begin
        csr_rdata_o = minstret_i;
        addr_ro     = 1'b1;
      end
      csr_pkg::CSR_MHPMCOUNTER3: begin
        csr_rdata_o = trap_count_i;
        addr_ro     = 1'b1;
      end
      default: begin
        addr_known = 1'b0;
      end
    endcase
  end

  // Unknown address, or a write to a counter
  assign csr_illegal_o = (csr_re_i || csr_we_i) && (!addr_known || (csr_we_i && addr_ro));

  // Trap entry wins over a CSR write
  assign write_ok  = csr_we_i && !csr_illegal_o && !trap_valid_i;
  assign mtvec_we  = write_ok && (csr_addr_i == csr_pkg::CSR_MTVEC);
  assign mepc_we   = write_ok && (csr_addr_i == csr_pkg::CSR_MEPC);
  assign mcause_we = write_ok && (csr_addr_i == csr_pkg::CSR_MCAUSE);

  // --------------------------------------------------
  // Register update
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtvec_q  <= `RETIRE_MTVEC_RESET;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      if (mtvec_we) begin
        mtvec_q <= csr_wdata_i;
      end
      if (trap_valid_i) begin
        mepc_q   <= trap_pc_i;
        mcause_q <= trap_cause_i;
      end else begin
        if (mepc_we) begin
          mepc_q <= csr_wdata_i;
        end
        if (mcause_we) begin
          mcause_q <= csr_wdata_i;
        end
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  // Only trap entry may touch mepc and mcause on an illegal access
  illegal_no_change_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_illegal_o |=> $stable(mtvec_q) &&
      ($past(trap_valid_i) || ($stable(mepc_q) && $stable(mcause_q))))
    else $error("illegal CSR access changed a register");

endmodule

`default_nettype wire

/* rtl/retire_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_macros.svh"

module retire_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instruction handshake
  input  logic                     req_i,
  input  logic [`RETIRE_XLEN-1:0]  instr_pc_i,
  input  retire_pkg::op_e          instr_op_i,
  input  logic [`RETIRE_REG_W-1:0] instr_rd_i,
  input  logic [`RETIRE_XLEN-1:0]  instr_data_i,
  input  logic [`RETIRE_CSR_W-1:0] instr_csr_i,
  output logic                     ack_o,
  // Register file writeback
  output logic                     wb_valid_o,
  output logic [`RETIRE_REG_W-1:0] wb_rd_o,
  output logic [`RETIRE_XLEN-1:0]  wb_data_o,
  // Pc redirect
  output logic                     redirect_valid_o,
  output logic [`RETIRE_XLEN-1:0]  redirect_pc_o,
  // CSR file
  output logic [`RETIRE_CSR_W-1:0] csr_addr_o,
  output logic [`RETIRE_XLEN-1:0]  csr_wdata_o,
  output logic                     csr_re_o,
  output logic                     csr_we_o,
  input  logic [`RETIRE_XLEN-1:0]  csr_rdata_i,
  input  logic                     csr_illegal_i,
  input  logic [`RETIRE_XLEN-1:0]  mtvec_i,
  input  logic [`RETIRE_XLEN-1:0]  mepc_i,
  output logic                     trap_valid_o,
  output logic [`RETIRE_XLEN-1:0]  trap_pc_o,
  output csr_pkg::cause_e          trap_cause_o,
  // Counter events
  output logic                     retired_o,
  output logic                     trapped_o
);

  retire_pkg::state_e state_q, state_d;

  // Instruction held for the whole handshake
  logic [`RETIRE_XLEN-1:0]  pc_q;
  retire_pkg::op_e          op_q;
  logic [`RETIRE_REG_W-1:0] rd_q;
  logic [`RETIRE_XLEN-1:0]  data_q;
  logic [`RETIRE_CSR_W-1:0] csr_q;

  logic in_ack;
  logic is_csr_op;
  logic is_ecall;
  logic is_mret;
  logic take_trap;

  // --------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      retire_pkg::ST_IDLE: begin
        if (req_i) begin
          state_d = retire_pkg::ST_ACK;
        end
      end
      retire_pkg::ST_ACK: begin
        state_d = retire_pkg::ST_WAIT_REQ_LOW;
      end
      retire_pkg::ST_WAIT_REQ_LOW: begin
        if (!req_i) begin
          state_d = retire_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = retire_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= retire_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture on the accepting edge
  always_ff @(posedge clk_i) begin
    if (state_q == retire_pkg::ST_IDLE && req_i) begin
      pc_q   <= instr_pc_i;
      op_q   <= instr_op_i;
      rd_q   <= instr_rd_i;
      data_q <= instr_data_i;
      csr_q  <= instr_csr_i;
    end
  end

  // --------------------------------------------------
  // Retire decision, only valid in ST_ACK
  // --------------------------------------------------
  assign in_ack    = (state_q == retire_pkg::ST_ACK);
  assign is_csr_op = (op_q == retire_pkg::OP_CSRR) || (op_q == retire_pkg::OP_CSRRW);
  assign is_ecall  = (op_q == retire_pkg::OP_ECALL);
  assign is_mret   = (op_q == retire_pkg::OP_MRET);
  assign take_trap = in_ack && (is_ecall || (is_csr_op && csr_illegal_i));

  assign ack_o = (state_q == retire_pkg::ST_ACK) || (state_q == retire_pkg::ST_WAIT_REQ_LOW);

  assign csr_addr_o   = csr_q;
  assign csr_wdata_o  = data_q;
  assign csr_re_o     = in_ack && is_csr_op;
  assign csr_we_o     = in_ack && (op_q == retire_pkg::OP_CSRRW);

  assign trap_valid_o = take_trap;
  assign trap_pc_o    = pc_q;
  assign trap_cause_o = is_ecall ? csr_pkg::CAUSE_ECALL_M : csr_pkg::CAUSE_ILLEGAL_INSTR;

  // CSR ops return the old value to rd
  assign wb_valid_o = in_ack && !take_trap && !is_mret && (rd_q != '0);
  assign wb_rd_o    = rd_q;
  assign wb_data_o  = is_csr_op ? csr_rdata_i : data_q;

  assign redirect_valid_o = in_ack && (take_trap || is_mret);
  assign redirect_pc_o    = take_trap ? mtvec_i : mepc_i;

  assign retired_o = in_ack && !take_trap;
  assign trapped_o = take_trap;

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  ack_release_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(ack_o) |-> !$past(req_i))
    else $error("ack_o dropped while req_i was still high");

  pulse_in_ack_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_valid_o || redirect_valid_o) |->
      $rose(ack_o) ##1 (!wb_valid_o && !redirect_valid_o))
    else $error("writeback or redirect pulse outside ST_ACK");

endmodule

`default_nettype wire

/* rtl/retire_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_macros.svh"

module retire_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instruction handshake
  input  logic                     req_i,
  input  logic [`RETIRE_XLEN-1:0]  instr_pc_i,
  input  retire_pkg::op_e          instr_op_i,
  input  logic [`RETIRE_REG_W-1:0] instr_rd_i,
  input  logic [`RETIRE_XLEN-1:0]  instr_data_i,
  input  logic [`RETIRE_CSR_W-1:0] instr_csr_i,
  output logic                     ack_o,
  // Writeback and redirect
  output logic                     wb_valid_o,
  output logic [`RETIRE_REG_W-1:0] wb_rd_o,
  output logic [`RETIRE_XLEN-1:0]  wb_data_o,
  output logic                     redirect_valid_o,
  output logic [`RETIRE_XLEN-1:0]  redirect_pc_o
);

  // --------------------------------------------------
  // Control to CSR file
  // --------------------------------------------------
  logic [`RETIRE_CSR_W-1:0] csr_addr;
  logic [`RETIRE_XLEN-1:0]  csr_wdata;
  logic                     csr_re;
  logic                     csr_we;
  logic [`RETIRE_XLEN-1:0]  csr_rdata;
  logic                     csr_illegal;
  logic [`RETIRE_XLEN-1:0]  mtvec;
  logic [`RETIRE_XLEN-1:0]  mepc;
  logic                     trap_valid;
  logic [`RETIRE_XLEN-1:0]  trap_pc;
  csr_pkg::cause_e          trap_cause;

  // Counter events and values
  logic                     retired;
  logic                     trapped;
  logic [`RETIRE_XLEN-1:0]  minstret;
  logic [`RETIRE_XLEN-1:0]  trap_count;

  retire_ctrl u_retire_ctrl (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .req_i            ( req_i            ),
    .instr_pc_i       ( instr_pc_i       ),
    .instr_op_i       ( instr_op_i       ),
    .instr_rd_i       ( instr_rd_i       ),
    .instr_data_i     ( instr_data_i     ),
    .instr_csr_i      ( instr_csr_i      ),
    .ack_o            ( ack_o            ),
    .wb_valid_o       ( wb_valid_o       ),
    .wb_rd_o          ( wb_rd_o          ),
    .wb_data_o        ( wb_data_o        ),
    .redirect_valid_o ( redirect_valid_o ),
    .redirect_pc_o    ( redirect_pc_o    ),
    .csr_addr_o       ( csr_addr         ),
    .csr_wdata_o      ( csr_wdata        ),
    .csr_re_o         ( csr_re           ),
    .csr_we_o         ( csr_we           ),
    .csr_rdata_i      ( csr_rdata        ),
    .csr_illegal_i    ( csr_illegal      ),
    .mtvec_i          ( mtvec            ),
    .mepc_i           ( mepc             ),
    .trap_valid_o     ( trap_valid       ),
    .trap_pc_o        ( trap_pc          ),
    .trap_cause_o     ( trap_cause       ),
    .retired_o        ( retired          ),
    .trapped_o        ( trapped          )
  );

  csr_regfile u_csr_regfile (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .csr_addr_i    ( csr_addr    ),
    .csr_wdata_i   ( csr_wdata   ),
    .csr_re_i      ( csr_re      ),
    .csr_we_i      ( csr_we      ),
    .csr_rdata_o   ( csr_rdata   ),
    .csr_illegal_o ( csr_illegal ),
    .trap_valid_i  ( trap_valid  ),
    .trap_pc_i     ( trap_pc     ),
    .trap_cause_i  ( trap_cause  ),
    .minstret_i    ( minstret    ),
    .trap_count_i  ( trap_count  ),
    .mtvec_o       ( mtvec       ),
    .mepc_o        ( mepc        )
  );

  perf_counters u_perf_counters (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .retired_i    ( retired    ),
    .trapped_i    ( trapped    ),
    .minstret_o   ( minstret   ),
    .trap_count_o ( trap_count )
  );

endmodule

`default_nettype wire

/* sim/tb_retire_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_macros.svh"

module tb_retire_top;

  localparam int TIMEOUT  = 50;
  localparam int NUM_RAND = 400;

  // CSR addresses as the reference model sees them
  localparam logic [11:0] A_MTVEC    = 12'h305;
  localparam logic [11:0] A_MEPC     = 12'h341;
  localparam logic [11:0] A_MCAUSE   = 12'h342;
  localparam logic [11:0] A_MINSTRET = 12'hB02;
  localparam logic [11:0] A_TRAPCNT  = 12'hB03;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_i;
  logic [`RETIRE_XLEN-1:0]  instr_pc_i;
  retire_pkg::op_e          instr_op_i;
  logic [`RETIRE_REG_W-1:0] instr_rd_i;
  logic [`RETIRE_XLEN-1:0]  instr_data_i;
  logic [`RETIRE_CSR_W-1:0] instr_csr_i;
  logic                     ack_o;
  logic                     wb_valid_o;
  logic [`RETIRE_REG_W-1:0] wb_rd_o;
  logic [`RETIRE_XLEN-1:0]  wb_data_o;
  logic                     redirect_valid_o;
  logic [`RETIRE_XLEN-1:0]  redirect_pc_o;

  integer seed;
  int     errors;
  int     checks;
  logic   timed_out;

  // Reference model state
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_minstret;
  logic [31:0] m_traps;

  // What the DUT showed during one handshake
  int          wb_count;
  int          redir_count;
  logic [4:0]  wb_rd_seen;
  logic [31:0] wb_data_seen;
  logic [31:0] redir_pc_seen;

  retire_top dut (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .req_i            ( req_i            ),
    .instr_pc_i       ( instr_pc_i       ),
    .instr_op_i       ( instr_op_i       ),
    .instr_rd_i       ( instr_rd_i       ),
    .instr_data_i     ( instr_data_i     ),
    .instr_csr_i      ( instr_csr_i      ),
    .ack_o            ( ack_o            ),
    .wb_valid_o       ( wb_valid_o       ),
    .wb_rd_o          ( wb_rd_o          ),
    .wb_data_o        ( wb_data_o        ),
    .redirect_valid_o ( redirect_valid_o ),
    .redirect_pc_o    ( redirect_pc_o    )
  );

  always #10 clk_i = ~clk_i;

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic record_outputs();
    if (wb_valid_o) begin
      wb_count++;
      wb_rd_seen   = wb_rd_o;
      wb_data_seen = wb_data_o;
    end
    if (redirect_valid_o) begin
      redir_count++;
      redir_pc_seen = redirect_pc_o;
    end
  endtask

  // --------------------------------------------------
  // Reference model, updated once per instruction
  // --------------------------------------------------
  task automatic predict(input logic [31:0] pc, input retire_pkg::op_e op,
                         input logic [4:0] rd, input logic [31:0] data,
                         input logic [11:0] csr, output logic exp_wb,
                         output logic [31:0] exp_data, output logic exp_redir,
                         output logic [31:0] exp_pc);
    logic        known;
    logic        ro;
    logic        trap;
    logic [31:0] old;
    logic [31:0] cause;
    known     = 1'b1;
    ro        = 1'b0;
    trap      = 1'b0;
    old       = '0;
    cause     = '0;
    exp_wb    = 1'b0;
    exp_data  = '0;
    exp_redir = 1'b0;
    exp_pc    = '0;
    case (csr)
      A_MTVEC:    old = m_mtvec;
      A_MEPC:     old = m_mepc;
      A_MCAUSE:   old = m_mcause;
      A_MINSTRET: begin
        old = m_minstret;
        ro  = 1'b1;
      end
      A_TRAPCNT: begin
        old = m_traps;
        ro  = 1'b1;
      end
      default:    known = 1'b0;
    endcase
    case (op)
      retire_pkg::OP_ALU: begin
        exp_wb   = (rd != 5'd0);
        exp_data = data;
      end
      retire_pkg::OP_CSRR, retire_pkg::OP_CSRRW: begin
        if (!known || (ro && op == retire_pkg::OP_CSRRW)) begin
          trap  = 1'b1;
          cause = 32'd2;
        end else begin
          exp_wb   = (rd != 5'd0);
          exp_data = old;
          if (op == retire_pkg::OP_CSRRW) begin
            if (csr == A_MTVEC) m_mtvec = data;
            if (csr == A_MEPC) m_mepc = data;
            if (csr == A_MCAUSE) m_mcause = data;
          end
        end
      end
      retire_pkg::OP_ECALL: begin
        trap  = 1'b1;
        cause = 32'd11;
      end
      default: begin
        // mret
        exp_redir = 1'b1;
        exp_pc    = m_mepc;
      end
    endcase
    if (trap) begin
      exp_redir = 1'b1;
      exp_pc    = m_mtvec;
      m_mepc    = pc;
      m_mcause  = cause;
      m_traps   = m_traps + 32'd1;
    end else begin
      m_minstret = m_minstret + 32'd1;
    end
  endtask

  // One four-phase handshake, sampled on falling edges
  task automatic send_instr(input logic [31:0] pc, input retire_pkg::op_e op,
                            input logic [4:0] rd, input logic [31:0] data,
                            input logic [11:0] csr);
    int cyc;
    wb_count    = 0;
    redir_count = 0;
    // One idle cycle first, ack must stay low without req
    @(negedge clk_i);
    check_eq("ack low while req low", 32'd0, {31'd0, ack_o});
    instr_pc_i   = pc;
    instr_op_i   = op;
    instr_rd_i   = rd;
    instr_data_i = data;
    instr_csr_i  = csr;
    req_i        = 1'b1;
    cyc = 0;
    do begin
      @(negedge clk_i);
      record_outputs();
      cyc++;
    end while (ack_o !== 1'b1 && cyc < TIMEOUT);
    if (ack_o !== 1'b1) begin
      errors++;
      $display("ack_o did not rise within %0d cycles of req_i going high", TIMEOUT);
      timed_out = 1'b1;
      req_i     = 1'b0;
      return;
    end
    req_i = 1'b0;
    cyc = 0;
    do begin
      @(negedge clk_i);
      record_outputs();
      cyc++;
    end while (ack_o !== 1'b0 && cyc < TIMEOUT);
    if (ack_o !== 1'b0) begin
      errors++;
      $display("ack_o did not fall within %0d cycles of req_i going low", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_one(input logic [31:0] pc, input retire_pkg::op_e op,
                         input logic [4:0] rd, input logic [31:0] data,
                         input logic [11:0] csr);
    logic        exp_wb;
    logic        exp_redir;
    logic [31:0] exp_data;
    logic [31:0] exp_pc;
    string       tag;
    tag = $sformatf("%s csr %h rd %0d", op.name(), csr, rd);
    predict(pc, op, rd, data, csr, exp_wb, exp_data, exp_redir, exp_pc);
    send_instr(pc, op, rd, data, csr);
    if (timed_out) return;
    check_eq({tag, " wb pulses"}, {31'd0, exp_wb}, wb_count);
    if (exp_wb && wb_count == 1) begin
      check_eq({tag, " wb rd"}, {27'd0, rd}, {27'd0, wb_rd_seen});
      check_eq({tag, " wb data"}, exp_data, wb_data_seen);
    end
    check_eq({tag, " redirect pulses"}, {31'd0, exp_redir}, redir_count);
    if (exp_redir && redir_count == 1) begin
      check_eq({tag, " redirect pc"}, exp_pc, redir_pc_seen);
    end
  endtask

  function automatic logic [11:0] pick_csr(input int unsigned sel, input int unsigned wild);
    case (sel % 8)
      0:       return A_MTVEC;
      1:       return A_MEPC;
      2:       return A_MCAUSE;
      3:       return A_MINSTRET;
      4:       return A_TRAPCNT;
      5:       return 12'h300;
      6:       return 12'hB04;
      default: return wild[11:0];
    endcase
  endfunction

  initial begin
    int unsigned r0;
    int unsigned r1;
    int unsigned r2;
    logic [2:0]  op_bits;
    seed         = 32'h42eb;
    errors       = 0;
    checks       = 0;
    timed_out    = 1'b0;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    instr_pc_i   = '0;
    instr_op_i   = retire_pkg::OP_ALU;
    instr_rd_i   = '0;
    instr_data_i = '0;
    instr_csr_i  = '0;
    m_mtvec      = `RETIRE_MTVEC_RESET;
    m_mepc       = '0;
    m_mcause     = '0;
    m_minstret   = '0;
    m_traps      = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_eq("ack after reset", 32'd0, {31'd0, ack_o});
    check_eq("wb_valid after reset", 32'd0, {31'd0, wb_valid_o});
    check_eq("redirect after reset", 32'd0, {31'd0, redirect_valid_o});

    // --------------------------------------------------
    // Directed sequence
    // --------------------------------------------------
    run_one(32'h0000_0040, retire_pkg::OP_CSRRW, 5'd1, 32'h0000_0200, A_MTVEC);
    run_one(32'h0000_0044, retire_pkg::OP_CSRR, 5'd2, 32'h0, A_MTVEC);
    run_one(32'h0000_1000, retire_pkg::OP_ECALL, 5'd0, 32'h0, 12'h0);
    run_one(32'h0000_0204, retire_pkg::OP_CSRR, 5'd3, 32'h0, A_MEPC);
    run_one(32'h0000_0208, retire_pkg::OP_CSRR, 5'd4, 32'h0, A_MCAUSE);
    run_one(32'h0000_020c, retire_pkg::OP_MRET, 5'd5, 32'h0, 12'h0);
    run_one(32'h0000_1004, retire_pkg::OP_CSRRW, 5'd6, 32'hdead_beef, A_MINSTRET);
    run_one(32'h0000_0208, retire_pkg::OP_CSRR, 5'd7, 32'h0, 12'h123);
    run_one(32'h0000_0210, retire_pkg::OP_CSRR, 5'd8, 32'h0, A_MCAUSE);
    run_one(32'h0000_0214, retire_pkg::OP_CSRR, 5'd9, 32'h0, A_MINSTRET);
    run_one(32'h0000_0218, retire_pkg::OP_CSRR, 5'd10, 32'h0, A_TRAPCNT);
    run_one(32'h0000_021c, retire_pkg::OP_ALU, 5'd0, 32'h1234_5678, 12'h0);

    // Random mix
    for (int n = 0; n < NUM_RAND && !timed_out; n++) begin
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      op_bits = 3'(r0 % 5);
      run_one(r1 & 32'hffff_fffc, retire_pkg::op_e'(op_bits),
              ((r0 / 8) % 4 == 0) ? 5'd0 : r2[4:0], $random(seed),
              pick_csr(r0 / 64, r2 / 32));
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/retire_pkg.sv
rtl/csr_pkg.sv
rtl/perf_counters.sv
rtl/csr_regfile.sv
rtl/retire_ctrl.sv
rtl/retire_top.sv
sim/tb_retire_top.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

# Build the testbench and the retire logic into one executable
verilator --binary --assert --timing -Wno-fatal \
  -f sources.f --top-module tb_retire_top -o tb_retire_top

./obj_dir/tb_retire_top > sim.log
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0
